//--- arcade_pkg.sv
//====================================================================
// Shared types of the arcade board shell: control sets, settings,
// pixels and VGA output, plus the PS/2 scan codes of the game keys
//====================================================================
`default_nettype none

package arcade_pkg;

	// One set of game controls, as a key map or a joystick
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} joy_t;

	// User settings; scanline_mode 1 dims odd lines by 25 %, 2 by 50 %
	typedef struct packed {
		logic       rotate;
		logic [1:0] scanline_mode;
	} shell_cfg_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb332_t;

	typedef struct packed {
		rgb332_t pix;
		logic    hs;
		logic    vs;
		logic    hblank;
		logic    vblank;
	} core_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

	//================================================================
	// PS/2 set 2 scan codes
	//================================================================
	// Arrow keys arrive behind the extended prefix
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_FIRE   = 8'h29;
	localparam logic [7:0] SC_START1 = 8'h16;
	localparam logic [7:0] SC_START2 = 8'h1E;
	localparam logic [7:0] SC_COIN   = 8'h2E;
	localparam logic [7:0] SC_BREAK  = 8'hF0;
	localparam logic [7:0] SC_EXT    = 8'hE0;

endpackage

`default_nettype wire

//--- ps2_receiver.sv
//====================================================================
// PS/2 receiver: line synchronizer, frame shifter, frame checks and
// an idle timeout that realigns the bit counter
//====================================================================
`default_nettype none

module ps2_receiver (
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire        ps2_clk,
	input  wire        ps2_data,
	output logic [7:0] code,
	output logic       code_valid
);

	localparam logic [11:0] IDLE_MAX = 12'hFFF;

	logic [1:0]  clk_sync;
	logic [1:0]  data_sync;
	logic        clk_prev;
	logic        clk_fall;
	logic [10:0] shift_q;
	logic [10:0] shift_next;
	logic [3:0]  bit_cnt;
	logic [11:0] idle_cnt;
	logic        last_bit;
	logic        frame_ok;

	// The device drives data while the clock is high, so the bit is
	// stable on the falling edge
	assign clk_fall   = clk_prev & ~clk_sync[1];
	assign last_bit   = (bit_cnt == 4'd10);
	assign shift_next = {data_sync[1], shift_q[10:1]};

	// Start low, odd parity over data and parity bit, stop high
	assign frame_ok = ~shift_next[0] & (^shift_next[9:1]) & shift_next[10];

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync   <= 2'b11;
			data_sync  <= 2'b11;
			clk_prev   <= 1'b1;
			bit_cnt    <= 4'd0;
			idle_cnt   <= 12'd0;
			code_valid <= 1'b0;
		end else begin
			clk_sync   <= {clk_sync[0], ps2_clk};
			data_sync  <= {data_sync[0], ps2_data};
			clk_prev   <= clk_sync[1];
			code_valid <= 1'b0;
			if (clk_fall) begin
				idle_cnt <= 12'd0;
				if (last_bit) begin
					bit_cnt    <= 4'd0;
					code_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (idle_cnt != IDLE_MAX) begin
				idle_cnt <= idle_cnt + 12'd1;
			end else begin
				// A broken frame has gone quiet, so start over with the next one
				bit_cnt <= 4'd0;
			end
		end
	end

	// Frame shifter and received byte
	always_ff @(posedge clk_sys) begin
		if (clk_fall) begin
			shift_q <= shift_next;
			if (last_bit) begin
				code <= shift_next[8:1];
			end
		end
	end

endmodule

`default_nettype wire

//--- key_joystick.sv
//====================================================================
// Keyboard to joystick: prefix tracking and held game-key state
//====================================================================
`default_nettype none

module key_joystick import arcade_pkg::*; (
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire  [7:0] code,
	input  wire        code_valid,
	output joy_t       kb_joy
);

	logic brk_flag;
	logic ext_flag;
	logic pressed;
	joy_t kb_next;

	assign pressed = ~brk_flag;

	// Arrows only count behind E0, the other keys only without it
	always_comb begin
		kb_next = kb_joy;
		if (ext_flag) begin
			case (code)
				SC_UP:    kb_next.up    = pressed;
				SC_DOWN:  kb_next.down  = pressed;
				SC_LEFT:  kb_next.left  = pressed;
				SC_RIGHT: kb_next.right = pressed;
				default:  kb_next = kb_joy;
			endcase
		end else begin
			case (code)
				SC_FIRE:   kb_next.fire   = pressed;
				SC_START1: kb_next.start1 = pressed;
				SC_START2: kb_next.start2 = pressed;
				SC_COIN:   kb_next.coin   = pressed;
				default:   kb_next = kb_joy;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			brk_flag <= 1'b0;
			ext_flag <= 1'b0;
			kb_joy   <= '0;
		end else if (code_valid) begin
			if (code == SC_BREAK) begin
				brk_flag <= 1'b1;
			end else if (code == SC_EXT) begin
				ext_flag <= 1'b1;
			end else begin
				// Any ordinary byte ends the prefix sequence
				kb_joy   <= kb_next;
				brk_flag <= 1'b0;
				ext_flag <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- control_mapper.sv
//====================================================================
// Control mapper: merges keyboard and joysticks, rotates the
// directions and builds the core's active-low input bytes
//====================================================================
`default_nettype none

module control_mapper import arcade_pkg::*; (
	input  wire        clk_sys,
	input  wire        rst_n,
	input  wire joy_t  kb_joy,
	input  wire joy_t  joy0,
	input  wire joy_t  joy1,
	input  wire        rotate,
	output logic [7:0] in0,
	output logic [7:0] in1
);

	joy_t merged;
	joy_t mapped;

	assign merged = kb_joy | joy0 | joy1;

	// Cabinet on its side: the stick is turned a quarter
	always_comb begin
		mapped = merged;
		if (rotate) begin
			mapped.up    = merged.right;
			mapped.right = merged.down;
			mapped.down  = merged.left;
			mapped.left  = merged.up;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			in0 <= 8'hFF;
			in1 <= 8'hFF;
		end else begin
			in0 <= ~{2'b00, mapped.coin, 1'b0,
				mapped.down, mapped.right, mapped.left, mapped.up};
			in1 <= ~{1'b0, mapped.start2, mapped.start1, mapped.fire, 4'b0000};
		end
	end

endmodule

`default_nettype wire

//--- video_expander.sv
//====================================================================
// Video expander: pixel clock enable, 3-3-2 to 6-6-6 expansion,
// blanking and scanline dimming on odd lines
//====================================================================
`default_nettype none

module video_expander import arcade_pkg::*; #(
	parameter int CLK_DIV = 4
) (
	input  wire              clk_sys,
	input  wire              rst_n,
	input  wire core_video_t core_video,
	input  wire        [1:0] scanline_mode,
	output logic             ce_pix,
	output vga_t             vga
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             hs_q;
	logic             line_odd;
	logic             line_odd_next;
	logic             blank;
	vga_t             vga_next;

	// Scanline effect for one 6-bit channel
	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] mode,
		input logic odd);
		logic [5:0] res;
		res = c;
		if (odd) begin
			case (mode)
				2'd1:    res = c - (c >> 2);
				2'd2:    res = c >> 1;
				default: res = c;
			endcase
		end
		return res;
	endfunction

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ce_pix  <= 1'b0;
		end else begin
			if (div_cnt == DIV_LAST) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			ce_pix <= (div_cnt == DIV_LAST);
		end
	end

	// The line count restarts with each frame
	always_comb begin
		line_odd_next = line_odd;
		if (core_video.vs) begin
			line_odd_next = 1'b0;
		end else if (core_video.hs && !hs_q) begin
			line_odd_next = ~line_odd;
		end
	end

	assign blank = core_video.hblank | core_video.vblank;

	always_comb begin
		vga_next.r  = dim({2{core_video.pix.r}}, scanline_mode, line_odd_next);
		vga_next.g  = dim({2{core_video.pix.g}}, scanline_mode, line_odd_next);
		vga_next.b  = dim({3{core_video.pix.b}}, scanline_mode, line_odd_next);
		vga_next.hs = core_video.hs;
		vga_next.vs = core_video.vs;
		if (blank) begin
			vga_next.r = '0;
			vga_next.g = '0;
			vga_next.b = '0;
		end
	end

	// Sample on the pixel enable and hold until the next one
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hs_q     <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else if (ce_pix) begin
			hs_q     <= core_video.hs;
			line_odd <= line_odd_next;
			vga      <= vga_next;
		end
	end

endmodule

`default_nettype wire

//--- sigma_delta_dac.sv
//====================================================================
// First-order sigma-delta DAC for one audio word
//====================================================================
`default_nettype none

module sigma_delta_dac #(
	parameter int DAC_WIDTH = 16
) (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire [DAC_WIDTH-1:0] sample,
	output logic                audio_bit
);

	logic [DAC_WIDTH-1:0] acc;
	logic [DAC_WIDTH:0]   sum;

	// The carry out of the running sum is the output density
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc       <= '0;
			audio_bit <= 1'b0;
		end else begin
			acc       <= sum[DAC_WIDTH-1:0];
			audio_bit <= sum[DAC_WIDTH];
		end
	end

endmodule

`default_nettype wire

//--- arcade_shell.sv
//====================================================================
// Arcade board shell top level: keyboard and joystick inputs, video
// expansion and audio DAC around the game core's ports
//====================================================================
`default_nettype none

module arcade_shell import arcade_pkg::*; #(
	parameter int CLK_DIV   = 4,
	parameter int DAC_WIDTH = 16
) (
	input  wire                 clk_sys,
	input  wire                 rst_n,
	input  wire                 ps2_clk,
	input  wire                 ps2_data,
	input  wire joy_t           joy0,
	input  wire joy_t           joy1,
	input  wire shell_cfg_t     cfg,
	input  wire core_video_t    core_video,
	input  wire [DAC_WIDTH-1:0] core_audio,
	output logic                ce_pix,
	output logic          [7:0] in0,
	output logic          [7:0] in1,
	output vga_t                vga,
	output logic                audio_l,
	output logic                audio_r
);

	logic [7:0] code;
	logic       code_valid;
	joy_t       kb_joy;
	logic       audio_bit;

	//================================================================
	// Controls
	//================================================================
	ps2_receiver ps2_receiver_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.code       (code),
		.code_valid (code_valid)
	);

	key_joystick key_joystick_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.code       (code),
		.code_valid (code_valid),
		.kb_joy     (kb_joy)
	);

	control_mapper control_mapper_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.kb_joy  (kb_joy),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (cfg.rotate),
		.in0     (in0),
		.in1     (in1)
	);

	//================================================================
	// Video and audio
	//================================================================
	video_expander #(
		.CLK_DIV (CLK_DIV)
	) video_expander_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.core_video    (core_video),
		.scanline_mode (cfg.scanline_mode),
		.ce_pix        (ce_pix),
		.vga           (vga)
	);

	sigma_delta_dac #(
		.DAC_WIDTH (DAC_WIDTH)
	) sigma_delta_dac_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sample    (core_audio),
		.audio_bit (audio_bit)
	);

	// The core is mono, so both channels carry the same stream
	assign audio_l = audio_bit;
	assign audio_r = audio_bit;

endmodule

`default_nettype wire

//--- tb_arcade_shell.sv
//====================================================================
// Testbench for the arcade shell: LFSR stimulus, key, mapper, pixel
// and DAC models, PS/2 frame driver and a watchdog
//====================================================================
`default_nettype none

module tb_arcade_shell import arcade_pkg::*; ();

	localparam int CLK_DIV      = 4;
	localparam int FRAME_CYCLES = 11 * 16;
	localparam int TEST_CYCLES  = 40 + 40 * (3 * FRAME_CYCLES + 2) + 10 * FRAME_CYCLES
		+ 4200 + 3 * 64 * CLK_DIV + 5 * 4100;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        ps2_clk;
	logic        ps2_data;
	joy_t        joy0;
	joy_t        joy1;
	shell_cfg_t  cfg;
	core_video_t core_video;
	logic [15:0] core_audio;
	logic        ce_pix;
	logic [7:0]  in0;
	logic [7:0]  in1;
	vga_t        vga;
	logic        audio_l;
	logic        audio_r;
	logic [15:0] lfsr_state = 16'd18;
	joy_t        kb_m;

	always #10 clk_sys = ~clk_sys;

	arcade_shell arcade_shell_i (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.joy0       (joy0),
		.joy1       (joy1),
		.cfg        (cfg),
		.core_video (core_video),
		.core_audio (core_audio),
		.ce_pix     (ce_pix),
		.in0        (in0),
		.in1        (in1),
		.vga        (vga),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	//================================================================
	// Random numbers, checks and models
	//================================================================
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	function automatic logic [15:0] expect_inputs(input joy_t m, input logic rot);
		joy_t d;
		d = m;
		if (rot) begin
			d.up    = m.right;
			d.right = m.down;
			d.down  = m.left;
			d.left  = m.up;
		end
		return {~{2'b00, d.coin, 1'b0, d.down, d.right, d.left, d.up},
			~{1'b0, d.start2, d.start1, d.fire, 4'b0000}};
	endfunction

	function automatic logic [5:0] dim_chan(input logic [5:0] c, input logic [1:0] mode,
		input logic odd);
		if (!odd || mode == 2'd0 || mode == 2'd3) begin
			return c;
		end
		if (mode == 2'd1) begin
			return c - (c >> 2);
		end
		return c >> 1;
	endfunction

	function automatic vga_t expect_pixel(input core_video_t v, input logic [1:0] mode,
		input logic odd);
		vga_t e;
		e = '0;
		e.hs = v.hs;
		e.vs = v.vs;
		if (!(v.hblank || v.vblank)) begin
			e.r = dim_chan({v.pix.r, v.pix.r}, mode, odd);
			e.g = dim_chan({v.pix.g, v.pix.g}, mode, odd);
			e.b = dim_chan({v.pix.b, v.pix.b, v.pix.b}, mode, odd);
		end
		return e;
	endfunction

	function automatic logic [7:0] key_code(input logic [2:0] k);
		case (k)
			3'd0:    return SC_UP;
			3'd1:    return SC_DOWN;
			3'd2:    return SC_LEFT;
			3'd3:    return SC_RIGHT;
			3'd4:    return SC_FIRE;
			3'd5:    return SC_START1;
			3'd6:    return SC_START2;
			default: return SC_COIN;
		endcase
	endfunction

	//================================================================
	// PS/2 driver
	//================================================================
	// Start, eight data bits LSB first, odd parity, stop; nbits cuts a frame short
	task automatic send_frame(input logic [7:0] data, input logic bad_parity, input int nbits);
		logic [10:0] frame;
		frame = {1'b1, ~^data ^ bad_parity, data, 1'b0};
		for (int i = 0; i < nbits; i++) begin
			ps2_data = frame[i];
			repeat (8) @(negedge clk_sys);
			ps2_clk = 1'b0;
			repeat (8) @(negedge clk_sys);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic send_key(input logic [2:0] k, input logic brk);
		if (k < 3'd4) begin
			send_frame(SC_EXT, 1'b0, 11);
		end
		if (brk) begin
			send_frame(SC_BREAK, 1'b0, 11);
		end
		send_frame(key_code(k), 1'b0, 11);
	endtask

	// Called ten cycles after the last falling PS/2 clock edge
	task automatic check_inputs(input string name);
		check(name, 32'(expect_inputs(kb_m | joy0 | joy1, cfg.rotate)), 32'({in0, in1}));
	endtask

	initial begin
		#(TEST_CYCLES * 3 / 2 * 20);
		$display("Run timed out before all tests finished");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	//================================================================
	// Test sequence
	//================================================================
	initial begin
		logic [31:0] r;
		logic [2:0]  key;
		logic        brk;
		core_video_t cv;
		logic        odd_m;
		logic        hs_m;
		int          ones;
		int          diff;
		rst_n      = 1'b0;
		ps2_clk    = 1'b1;
		ps2_data   = 1'b1;
		joy0       = '0;
		joy1       = '0;
		cfg        = '0;
		core_video = '0;
		core_audio = '0;
		kb_m       = '0;
		repeat (2) @(negedge clk_sys);
		rst_n = 1'b1;

		// Idle state after reset and the pixel enable period
		check("reset ce_pix", 32'd0, 32'(ce_pix));
		check("reset in0", 32'hFF, 32'(in0));
		check("reset in1", 32'hFF, 32'(in1));
		check("reset vga", 32'd0, 32'(vga));
		check("reset audio_l", 32'd0, 32'(audio_l));
		do @(negedge clk_sys); while (!ce_pix);
		for (int i = 1; i <= 3 * CLK_DIV; i++) begin
			@(negedge clk_sys);
			check("ce_pix period", 32'(i % CLK_DIV == 0), 32'(ce_pix));
		end

		// Random make and break codes with changing joysticks and rotation
		for (int s = 0; s < 5; s++) begin
			rand_bits(16, r);
			joy0 = r[7:0] & r[15:8];
			rand_bits(16, r);
			joy1 = r[7:0] & r[15:8];
			rand_bits(1, r);
			cfg.rotate = r[0];
			for (int n = 0; n < 8; n++) begin
				rand_bits(4, r);
				key = r[2:0];
				brk = r[3];
				send_key(key, brk);
				kb_m[3'd7 - key] = ~brk;
				repeat (2) @(negedge clk_sys);
				check_inputs("key sequence");
			end
		end

		// Dropped and ignored frames, then recovery after a cut frame
		joy0 = '0;
		joy1 = '0;
		// Coin starts released, so a coin make that slips through shows up
		send_key(3'd7, 1'b1);
		kb_m.coin = 1'b0;
		send_frame(SC_BREAK, 1'b1, 11);
		send_frame(SC_FIRE, 1'b0, 11);
		kb_m.fire = 1'b1;
		repeat (2) @(negedge clk_sys);
		check_inputs("dropped break prefix");
		send_frame(SC_COIN, 1'b1, 11);
		repeat (2) @(negedge clk_sys);
		check_inputs("bad parity");
		send_frame(8'h1C, 1'b0, 11);
		repeat (2) @(negedge clk_sys);
		check_inputs("unknown code");
		send_frame(SC_EXT, 1'b0, 11);
		send_frame(SC_COIN, 1'b0, 11);
		repeat (2) @(negedge clk_sys);
		check_inputs("coin behind E0");
		send_frame(SC_BREAK, 1'b0, 5);
		repeat (4200) @(negedge clk_sys);
		send_frame(SC_BREAK, 1'b0, 11);
		send_frame(SC_FIRE, 1'b0, 11);
		kb_m.fire = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_inputs("after idle timeout");

		// Pixels in scanline modes 0 to 2; the pixel is driven just before its sampling edge
		odd_m = 1'b0;
		hs_m  = 1'b0;
		for (int mode = 0; mode < 3; mode++) begin
			cfg.scanline_mode = 2'(mode);
			for (int p = 0; p < 64; p++) begin
				do @(negedge clk_sys); while (!ce_pix);
				rand_bits(12, r);
				cv.pix    = r[7:0];
				cv.hblank = r[8] & r[9];
				cv.vblank = r[10] & r[11];
				cv.hs     = (p % 8 == 7);
				cv.vs     = (p < 2);
				core_video = cv;
				if (cv.vs) begin
					odd_m = 1'b0;
				end else if (cv.hs && !hs_m) begin
					odd_m = ~odd_m;
				end
				hs_m = cv.hs;
				@(negedge clk_sys);
				check("video pixel", 32'(expect_pixel(cv, cfg.scanline_mode, odd_m)), 32'(vga));
			end
		end

		// Pulse density of the DAC for constant samples
		for (int t = 0; t < 5; t++) begin
			rand_bits(16, r);
			core_audio = r[15:0];
			repeat (4) @(negedge clk_sys);
			ones = 0;
			for (int c = 0; c < 4096; c++) begin
				@(negedge clk_sys);
				check("audio channels", 32'(audio_l), 32'(audio_r));
				if (audio_l) begin
					ones++;
				end
			end
			diff = ones * 16 - int'(core_audio);
			check("audio density",
				32'((diff >= -16 && diff <= 16) ? ones : int'(core_audio) / 16), 32'(ones));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
arcade_pkg.sv
ps2_receiver.sv
key_joystick.sv
control_mapper.sv
video_expander.sv
sigma_delta_dac.sv
arcade_shell.sv
tb_arcade_shell.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_arcade_shell -f sim.f -o tb_arcade_shell &&
./obj_dir/tb_arcade_shell || exit 1
